//--- bench/tb_vector_display.sv
// testbench for the vector display core with lfsr driven enable, bresenham reference model and checks
`timescale 1ns/10ps

module tb_vector_display;

    localparam int STEP_DIV     = 4;    // enabled cycles per point
    localparam int OUT_WIDTH    = 8;    // dac code width under test
    localparam int FRAMES       = 3;    // full frames compared before the run ends
    localparam int STROBE_LIMIT = 2000; // cycles allowed between two strobes

    logic                 clk_ss = 1'b0;
    logic                 rst;
    logic                 enable;
    logic [OUT_WIDTH-1:0] x_ch;
    logic [OUT_WIDTH-1:0] y_ch;
    logic                 point_strobe;
    logic                 frame_start;

    logic [31:0]          lfsr;          // random source state
    logic [OUT_WIDTH-1:0] exp_x [$];     // expected x codes of one frame in drawing order
    logic [OUT_WIDTH-1:0] exp_y [$];
    bit                   exp_first [$]; // expected frame_start for each point
    logic [OUT_WIDTH-1:0] last_x;        // codes carried by the last strobe
    logic [OUT_WIDTH-1:0] last_y;
    logic                 en_seen;       // enable as the dut sampled it on the last edge
    int                   en_count;      // enabled edges since the last stepper tick
    int                   hold_left;     // cycles left in a forced enable low run
    int                   holds_done;    // long low runs driven so far
    int                   pt_idx;        // position in the frame of the next point
    int                   points_done;

    top_vector_display #(
        .OUT_WIDTH (OUT_WIDTH),
        .STEP_DIV  (STEP_DIV)
    ) u_dut (
        .clk_ss       (clk_ss),
        .rst          (rst),
        .enable       (enable),
        .x_ch         (x_ch),
        .y_ch         (y_ch),
        .point_strobe (point_strobe),
        .frame_start  (frame_start)
    );

    always #10 clk_ss = ~clk_ss; // 20 ns period

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // taps 32, 22, 2 and 1 give a maximal sequence
        return {s[30:0], fb};
    endfunction

    // collects n fresh bits with one lfsr step per bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] code_of(input int c);
        return 8'(c + 128); // offset binary shifts the signed range up by half scale
    endfunction

    task automatic report_mismatch(input string name, input int exp_v, input int act_v);
        $display("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, name, exp_v, act_v);
        $display("TEST FAIL");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic report_problem(input string what);
        $display("ERROR time=%0t %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "%s", what);
    endtask

    // walks every table segment with the integer bresenham rule including the end point
    task automatic build_model;
        int  x;
        int  y;
        int  x1;
        int  y1;
        int  dx;
        int  dy;
        int  sx;
        int  sy;
        int  err;
        int  e2;
        int  steps;
        bit  done;
        for (int s = 0; s < vector_pkg::NUM_SEGS; s++) begin
            x     = int'(vector_pkg::SEG_X0[s]);
            y     = int'(vector_pkg::SEG_Y0[s]);
            x1    = int'(vector_pkg::SEG_X1[s]);
            y1    = int'(vector_pkg::SEG_Y1[s]);
            dx    = (x1 > x) ? x1 - x : x - x1;  // |dx|
            dy    = (y1 > y) ? y - y1 : y1 - y;  // -|dy|
            sx    = (x < x1) ? 1 : -1;
            sy    = (y < y1) ? 1 : -1;
            err   = dx + dy;
            steps = 0;
            done  = 1'b0;
            while (!done) begin
                exp_x.push_back(code_of(x));
                exp_y.push_back(code_of(y));
                exp_first.push_back((s == 0) && (steps == 0)); // frame mark on the very first point
                if ((x == x1) && (y == y1)) begin
                    done = 1'b1;
                end else begin
                    e2 = 2 * err;
                    if (e2 >= dy) begin
                        err = err + dy;
                        x   = x + sx;
                    end
                    if (e2 <= dx) begin
                        err = err + dx;
                        y   = y + sy;
                    end
                end
                steps = steps + 1;
                if (steps > 512) begin
                    report_problem("reference walk never reached the end of a segment");
                end
            end
        end
    endtask

    // picks the enable level for the next edge and now and then forces a long low run
    task automatic drive_enable;
        logic en_next;
        if (hold_left > 0) begin
            en_next   = 1'b0;
            hold_left = hold_left - 1;
        end else if (take_bits(7) == 8'd0) begin
            hold_left  = 23 + int'(take_bits(6)); // 24 to 87 low cycles counting this one
            holds_done = holds_done + 1;
            en_next    = 1'b0;
        end else begin
            en_next = (take_bits(2) != 8'd0); // high three times in four
        end
        enable <= en_next;
    endtask

    // drives on the rising edge and checks what that edge produced on the falling edge
    task automatic run_cycle(output bit got);
        @(posedge clk_ss);
        en_seen = enable;      // level the dut samples on this edge
        drive_enable();
        @(negedge clk_ss);
        got = point_strobe;
        if (point_strobe) begin
            assert (en_count == STEP_DIV)
                else report_mismatch("enabled cycles per point", STEP_DIV, en_count);
            assert (x_ch == exp_x[pt_idx])
                else report_mismatch("x_ch", int'(exp_x[pt_idx]), int'(x_ch));
            assert (y_ch == exp_y[pt_idx])
                else report_mismatch("y_ch", int'(exp_y[pt_idx]), int'(y_ch));
            assert (frame_start == exp_first[pt_idx])
                else report_mismatch("frame_start", int'(exp_first[pt_idx]), int'(frame_start));
            last_x      = x_ch;
            last_y      = y_ch;
            en_count    = 0;
            pt_idx      = (pt_idx + 1 == exp_x.size()) ? 0 : pt_idx + 1; // wrap into the next frame
            points_done = points_done + 1;
        end else begin
            assert (en_count < STEP_DIV)
                else report_problem("point_strobe missing after STEP_DIV enabled cycles");
            assert (frame_start == 1'b0)
                else report_mismatch("frame_start", 0, int'(frame_start));
            assert (x_ch == last_x)
                else report_mismatch("x_ch", int'(last_x), int'(x_ch));
            assert (y_ch == last_y)
                else report_mismatch("y_ch", int'(last_y), int'(y_ch));
        end
        if (en_seen) begin
            en_count = en_count + 1;
        end
    endtask

    task automatic wait_strobe;
        bit got;
        int waited;
        got    = 1'b0;
        waited = 0;
        while (!got) begin
            run_cycle(got);
            waited = waited + 1;
            if (!got && (waited >= STROBE_LIMIT)) begin
                report_problem("timed out waiting for point_strobe");
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        enable      = 1'b0;
        lfsr        = 32'h6dfb;
        last_x      = '0;      // reset codes until the first strobe
        last_y      = '0;
        en_count    = 0;
        hold_left   = 0;
        holds_done  = 0;
        pt_idx      = 0;
        points_done = 0;
        build_model();
        repeat (3) @(posedge clk_ss);
        rst <= 1'b0;           // dut sees reset on three edges
        @(negedge clk_ss);
        assert (x_ch == '0) else report_mismatch("x_ch", 0, int'(x_ch));
        assert (y_ch == '0) else report_mismatch("y_ch", 0, int'(y_ch));
        assert (point_strobe == 1'b0) else report_mismatch("point_strobe", 0, int'(point_strobe));
        assert (frame_start == 1'b0) else report_mismatch("frame_start", 0, int'(frame_start));
        while (points_done < FRAMES * exp_x.size()) begin
            wait_strobe();
        end
        assert (holds_done > 0) else report_problem("no long enable low run was driven");
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- files.f
source/vector_pkg.sv
source/channel_dac.sv
source/segment_sequencer.sv
source/line_stepper.sv
source/top_vector_display.sv
bench/tb_vector_display.sv

//--- run_sim.sh
#!/bin/sh
# builds the vector display testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_vector_display \
    -f files.f -o vsim_vector_display || { echo "run_sim: build failed"; exit 1; }
out=$(./obj_dir/vsim_vector_display 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'TEST PASS' && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
exit 0

//--- source/channel_dac.sv
// channel dac coder turning a signed coordinate into a registered offset binary code
`timescale 1ns/10ps

module channel_dac #(
    parameter int OUT_WIDTH = 8 // pins driven on the resistor ladder
) (
    input  logic                  clk_ss,
    input  logic                  rst,
    input  vector_pkg::coord_t    coord, // beam position in two's complement
    output logic [OUT_WIDTH-1:0]  code   // offset binary code with 0 at the most negative position
);

    localparam int CODE_W = $bits(vector_pkg::dac_code_t); // native width of the coder

    vector_pkg::dac_code_t offset;  // coordinate with its sign bit flipped
    logic [OUT_WIDTH-1:0]  scaled;  // offset code fitted to the output width

    // flipping the sign bit shifts the range up by half scale
    // so -128 lands on 0, 0 on mid scale and 127 on full scale
    assign offset = {~coord[CODE_W-1], coord[CODE_W-2:0]};

    generate
        if (OUT_WIDTH == CODE_W) begin : g_same
            assign scaled = offset;                           // widths match
        end else if (OUT_WIDTH < CODE_W) begin : g_narrow
            assign scaled = offset[CODE_W-1 -: OUT_WIDTH];    // drop the low bits
        end else begin : g_wide
            assign scaled = {offset, {(OUT_WIDTH - CODE_W){1'b0}}}; // zeros below keep full scale
        end
    endgenerate

    // registered so both channels change on the same edge
    always_ff @(posedge clk_ss) begin
        if (rst) begin
            code <= '0;
        end else begin
            code <= scaled; // follows the stepper point one cycle later
        end
    end

endmodule

//--- source/line_stepper.sv
// line stepper with step rate divider and bresenham walk emitting one point per tick
`timescale 1ns/10ps

module line_stepper #(
    parameter int STEP_DIV = 4 // enabled cycles per point which must be at least 3 for IDLE and LOAD
) (
    input  logic               clk_ss,
    input  logic               rst,
    input  logic               enable,   // low level freezes the divider and the walk
    input  vector_pkg::coord_t seg_x0,   // segment endpoints from the sequencer
    input  vector_pkg::coord_t seg_y0,
    input  vector_pkg::coord_t seg_x1,
    input  vector_pkg::coord_t seg_y1,
    input  logic               seg_first, // segment starts the frame
    output logic               seg_next,  // one cycle pulse after the last point of a segment
    output vector_pkg::coord_t pt_x,      // last emitted point
    output vector_pkg::coord_t pt_y,
    output logic               pt_valid,  // one cycle pulse with each new point
    output logic               pt_first   // pulse marks the first point of the frame
);

    localparam int CNT_W = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1; // divider counter width

    typedef logic signed [8:0]  delta_t; // coordinate difference one bit wider than coord_t
    typedef logic signed [11:0] err_t;   // error term with room for twice the largest delta sum

    vector_pkg::step_state_t state;
    logic [CNT_W-1:0]        div_cnt;  // enabled cycles since the last tick
    logic                    tick;     // a point is due this cycle
    logic                    at_first; // next emitted point opens the frame

    vector_pkg::coord_t cur_x;   // point to emit on the next tick
    vector_pkg::coord_t cur_y;
    vector_pkg::coord_t end_x;   // latched end point of the segment
    vector_pkg::coord_t end_y;
    delta_t             dx;      // absolute x delta
    delta_t             dy;      // negated absolute y delta
    logic               sx_neg;  // x walks downwards
    logic               sy_neg;  // y walks downwards
    err_t               err;     // bresenham error starting at dx + dy

    delta_t             ld_dx;   // raw differences of the presented segment
    delta_t             ld_dy;
    delta_t             abs_dx;
    delta_t             neg_dy;
    err_t               e2;      // doubled error compared against both deltas
    logic               at_end;  // current point is the segment end
    vector_pkg::coord_t nx_x;    // point after the current one
    vector_pkg::coord_t nx_y;
    err_t               nx_err;

    // divider only counts cycles where enable is high
    assign tick = enable && (div_cnt == CNT_W'(STEP_DIV - 1));

    always_ff @(posedge clk_ss) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (enable) begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1; // wrap on the tick
        end
    end

    // setup values for LOAD taken straight from the sequencer outputs
    always_comb begin
        ld_dx  = delta_t'(seg_x1) - delta_t'(seg_x0);  // sign extended so it cannot overflow
        ld_dy  = delta_t'(seg_y1) - delta_t'(seg_y0);
        abs_dx = ld_dx[8] ? -ld_dx : ld_dx;            // magnitude of the x run
        neg_dy = ld_dy[8] ? ld_dy : -ld_dy;            // y kept negative as the classic form wants
    end

    // one bresenham step that works in every octant since both axes test the same error
    always_comb begin
        e2     = err <<< 1;
        at_end = (cur_x == end_x) && (cur_y == end_y);
        nx_x   = cur_x;
        nx_y   = cur_y;
        nx_err = err;
        if (e2 >= err_t'(dy)) begin
            nx_err = nx_err + err_t'(dy);                   // x moves and the error pays for it
            nx_x   = sx_neg ? cur_x - 8'sd1 : cur_x + 8'sd1;
        end
        if (e2 <= err_t'(dx)) begin
            nx_err = nx_err + err_t'(dx);                   // y catches up
            nx_y   = sy_neg ? cur_y - 8'sd1 : cur_y + 8'sd1;
        end
    end

    // control side with strobes and state
    always_ff @(posedge clk_ss) begin
        if (rst) begin
            state    <= vector_pkg::IDLE;
            seg_next <= 1'b0;
            pt_valid <= 1'b0;
            pt_first <= 1'b0;
            at_first <= 1'b0;
            pt_x     <= 8'sh80; // most negative point keeps the dac codes at zero
            pt_y     <= 8'sh80;
        end else begin
            seg_next <= 1'b0;   // pulses last one cycle even with enable low
            pt_valid <= 1'b0;
            pt_first <= 1'b0;
            if (enable) begin
                case (state)
                    vector_pkg::IDLE: begin
                        state <= vector_pkg::LOAD; // sequencer has settled by now
                    end
                    vector_pkg::LOAD: begin
                        at_first <= seg_first;
                        state    <= vector_pkg::DRAW;
                    end
                    vector_pkg::DRAW: begin
                        if (tick) begin
                            pt_x     <= cur_x;
                            pt_y     <= cur_y;
                            pt_valid <= 1'b1;
                            pt_first <= at_first;  // only the opening point of segment 0
                            at_first <= 1'b0;
                            if (at_end) begin
                                seg_next <= 1'b1;  // end point drawn so ask for the next one
                                state    <= vector_pkg::IDLE;
                            end
                        end
                    end
                    default: state <= vector_pkg::IDLE;
                endcase
            end
        end
    end

    // walk registers load in LOAD and step on every DRAW tick until the end point
    always_ff @(posedge clk_ss) begin
        if (enable && (state == vector_pkg::LOAD)) begin
            cur_x  <= seg_x0;
            cur_y  <= seg_y0;
            end_x  <= seg_x1;
            end_y  <= seg_y1;
            dx     <= abs_dx;
            dy     <= neg_dy;
            sx_neg <= ld_dx[8];
            sy_neg <= ld_dy[8];
            err    <= err_t'(abs_dx) + err_t'(neg_dy); // initial error dx + dy
        end else if (tick && (state == vector_pkg::DRAW) && !at_end) begin
            cur_x  <= nx_x;
            cur_y  <= nx_y;
            err    <= nx_err;
        end
    end

endmodule

//--- source/segment_sequencer.sv
// segment sequencer walking the package segment table and presenting endpoints to the stepper
`timescale 1ns/10ps

module segment_sequencer (
    input  logic               clk_ss,
    input  logic               rst,
    input  logic               seg_next,  // stepper finished the current segment
    output vector_pkg::coord_t seg_x0,    // start point of the current segment
    output vector_pkg::coord_t seg_y0,
    output vector_pkg::coord_t seg_x1,    // end point which is drawn as well
    output vector_pkg::coord_t seg_y1,
    output logic               seg_first  // high while segment 0 is presented
);

    vector_pkg::seg_idx_t seg_idx;  // index of the segment now on the outputs
    vector_pkg::seg_idx_t next_idx; // index that follows and wraps at the end of the frame
    logic                 last_seg; // current segment closes the frame

    // the table is a constant so the lookup folds into a small rom
    always_comb begin
        last_seg = (seg_idx == vector_pkg::seg_idx_t'(vector_pkg::NUM_SEGS - 1)); // frame end
        if (last_seg) begin
            next_idx = '0;                // wrap back to the first segment
        end else begin
            next_idx = seg_idx + 1'b1;    // plain step through the table
        end
    end

    // index and endpoints move together so the stepper never sees a mixed segment
    always_ff @(posedge clk_ss) begin
        if (rst) begin
            seg_idx   <= '0;                       // frame always starts at segment 0
            seg_x0    <= vector_pkg::SEG_X0[0];    // present segment 0 straight out of reset
            seg_y0    <= vector_pkg::SEG_Y0[0];
            seg_x1    <= vector_pkg::SEG_X1[0];
            seg_y1    <= vector_pkg::SEG_Y1[0];
            seg_first <= 1'b1;                     // segment 0 carries the frame mark
        end else if (seg_next) begin
            seg_idx   <= next_idx;                 // advance one entry per request
            seg_x0    <= vector_pkg::SEG_X0[next_idx];
            seg_y0    <= vector_pkg::SEG_Y0[next_idx];
            seg_x1    <= vector_pkg::SEG_X1[next_idx];
            seg_y1    <= vector_pkg::SEG_Y1[next_idx];
            seg_first <= last_seg;                 // wrapping means segment 0 comes next
        end
    end

endmodule

//--- source/top_vector_display.sv
// vector display core with segment sequencer, line stepper, two dac coders and strobe alignment
`timescale 1ns/10ps

module top_vector_display #(
    parameter int OUT_WIDTH = vector_pkg::DAC_WIDTH, // pins per dac channel
    parameter int STEP_DIV  = 4                      // enabled cycles between points
) (
    input  logic                 clk_ss,
    input  logic                 rst,
    input  logic                 enable,       // low holds the beam where it is
    output logic [OUT_WIDTH-1:0] x_ch,         // x dac code
    output logic [OUT_WIDTH-1:0] y_ch,         // y dac code
    output logic                 point_strobe, // high with each new pair of codes
    output logic                 frame_start   // high with the first point of the frame
);

    vector_pkg::coord_t seg_x0;    // current segment from the sequencer
    vector_pkg::coord_t seg_y0;
    vector_pkg::coord_t seg_x1;
    vector_pkg::coord_t seg_y1;
    logic               seg_first;
    logic               seg_next;  // stepper request for the next segment
    vector_pkg::coord_t pt_x;      // stepper point one cycle ahead of the codes
    vector_pkg::coord_t pt_y;
    logic               pt_valid;
    logic               pt_first;

    segment_sequencer u_sequencer (
        .clk_ss    (clk_ss),
        .rst       (rst),
        .seg_next  (seg_next),
        .seg_x0    (seg_x0),
        .seg_y0    (seg_y0),
        .seg_x1    (seg_x1),
        .seg_y1    (seg_y1),
        .seg_first (seg_first)
    );

    line_stepper #(
        .STEP_DIV (STEP_DIV)
    ) u_stepper (
        .clk_ss    (clk_ss),
        .rst       (rst),
        .enable    (enable),
        .seg_x0    (seg_x0),
        .seg_y0    (seg_y0),
        .seg_x1    (seg_x1),
        .seg_y1    (seg_y1),
        .seg_first (seg_first),
        .seg_next  (seg_next),
        .pt_x      (pt_x),
        .pt_y      (pt_y),
        .pt_valid  (pt_valid),
        .pt_first  (pt_first)
    );

    channel_dac #(.OUT_WIDTH(OUT_WIDTH)) u_x_dac (
        .clk_ss (clk_ss),
        .rst    (rst),
        .coord  (pt_x),
        .code   (x_ch)
    );

    channel_dac #(.OUT_WIDTH(OUT_WIDTH)) u_y_dac (
        .clk_ss (clk_ss),
        .rst    (rst),
        .coord  (pt_y),
        .code   (y_ch)
    );

    // one register stage matching the coder latency so strobes land with the codes
    always_ff @(posedge clk_ss) begin
        if (rst) begin
            point_strobe <= 1'b0;
            frame_start  <= 1'b0;
        end else begin
            point_strobe <= pt_valid;
            frame_start  <= pt_first; // only ever high together with pt_valid
        end
    end

endmodule

//--- source/vector_pkg.sv
// vector display package with coordinate and dac code types, segment table and stepper states
package vector_pkg;

    typedef logic signed [7:0] coord_t;    // beam position in two's complement with 0 at screen centre
    typedef logic        [7:0] dac_code_t; // offset binary code as the resistor ladder wants it

    localparam int DAC_WIDTH = 8; // pins per channel on the dac headers
    localparam int NUM_SEGS  = 6; // segments drawn per frame

    typedef logic [2:0] seg_idx_t; // wide enough for NUM_SEGS entries

    // square of side 120 centred on the screen, then both diagonals
    // segment 0 is the bottom edge with no y movement, segment 1 the right edge with no x movement
    // segments 2 and 3 walk back in negative x and negative y, segment 5 runs with x falling
    localparam coord_t SEG_X0 [NUM_SEGS] = '{
        -8'sd60, 8'sd60, 8'sd60, -8'sd60, -8'sd60, 8'sd60
    };
    localparam coord_t SEG_Y0 [NUM_SEGS] = '{
        -8'sd60, -8'sd60, 8'sd60, 8'sd60, -8'sd60, -8'sd60
    };
    localparam coord_t SEG_X1 [NUM_SEGS] = '{
        8'sd60, 8'sd60, -8'sd60, -8'sd60, 8'sd60, -8'sd60
    };
    localparam coord_t SEG_Y1 [NUM_SEGS] = '{
        -8'sd60, 8'sd60, 8'sd60, -8'sd60, 8'sd60, 8'sd60
    };

    typedef enum logic [1:0] {
        IDLE, // waits one cycle so the sequencer can present the next segment
        LOAD, // latches endpoints and sets up deltas, signs and error
        DRAW  // emits one point per divider tick
    } step_state_t;

endpackage
